// ==== decoder_cfg.svh ====
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// Widths.
`define DATA_W      32
`define REG_ADDR_W  5
`define SHAMT_W     5
`define IMM_W       16
`define OP_W        6
`define FUNC_W      6
`define ALU_OP_W    5
`define SEL_W       2
`define EXC_W       5

// Primary opcodes.
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000

// SPECIAL function field.
`define FUNC_SLL     6'b000000
`define FUNC_SRL     6'b000010
`define FUNC_SRA     6'b000011
`define FUNC_SLLV    6'b000100
`define FUNC_SRLV    6'b000110
`define FUNC_SRAV    6'b000111
`define FUNC_JR      6'b001000
`define FUNC_MOVZ    6'b001010
`define FUNC_MOVN    6'b001011
`define FUNC_SYSCALL 6'b001100
`define FUNC_MFHI    6'b010000
`define FUNC_MTHI    6'b010001
`define FUNC_MFLO    6'b010010
`define FUNC_MTLO    6'b010011
`define FUNC_MULT    6'b011000
`define FUNC_MULTU   6'b011001
`define FUNC_DIV     6'b011010
`define FUNC_DIVU    6'b011011
`define FUNC_ADD     6'b100000
`define FUNC_ADDU    6'b100001
`define FUNC_SUB     6'b100010
`define FUNC_SUBU    6'b100011
`define FUNC_AND     6'b100100
`define FUNC_OR      6'b100101
`define FUNC_XOR     6'b100110
`define FUNC_NOR     6'b100111
`define FUNC_SLT     6'b101010
`define FUNC_SLTU    6'b101011

// COP0 rs field with the CO bit set.
`define RS_ERET      5'b10000

// Exception cause codes.
`define EXC_SYS      5'd8
`define EXC_RI       5'd10

`endif

// ==== decoder_pkg.sv ====
`include "decoder_cfg.svh"

package decoder_pkg;

    typedef struct packed {
        logic [`OP_W-1:0]       op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`SHAMT_W-1:0]    shamt;
        logic [`FUNC_W-1:0]     func;
    } r_fmt_t;

    typedef struct packed {
        logic [`OP_W-1:0]       op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`IMM_W-1:0]      imm;
    } i_fmt_t;

    // One instruction word seen as R-type or I-type.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MOVN, ALU_MOVZ,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    typedef enum logic [`SEL_W-1:0] {
        GPR_SEL_ALU, GPR_SEL_HI, GPR_SEL_LO
    } gpr_sel_e;

    typedef enum logic [`SEL_W-1:0] {
        LH_SEL_GPR, LH_SEL_MUL, LH_SEL_DIV
    } lohi_sel_e;

    typedef struct packed {
        alu_op_e            alu_op;
        logic [`DATA_W-1:0] opr1;
        logic [`DATA_W-1:0] opr2;
    } alu_bundle_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] gpr_waddr;
        logic                   gpr_we;
        logic                   hi_we;
        logic                   lo_we;
        gpr_sel_e               gpr_sel;
        lohi_sel_e              lohi_sel;
        logic                   is_jump;
        logic                   is_syscall;
        logic                   is_eret;
        logic                   is_div;
        logic                   exc;
        logic [`EXC_W-1:0]      exc_cause;
    } ctrl_bundle_t;

    typedef struct packed {
        alu_bundle_t  alu;
        ctrl_bundle_t ctrl;
    } decode_t;

endpackage

// ==== operand_select.sv ====
`include "decoder_cfg.svh"

module operand_select (
    input  decoder_pkg::instr_u      i_instr,
    input  logic [`DATA_W-1:0]       i_rs_rdata,
    input  logic [`DATA_W-1:0]       i_rt_rdata,
    output decoder_pkg::alu_bundle_t o_alu
);

    logic [`DATA_W-1:0]   shamt_ext;
    logic [`DATA_W-1:0]   imm_zext;
    logic [`DATA_W-1:0]   imm_sext;
    decoder_pkg::alu_op_e func_op;
    decoder_pkg::alu_op_e imm_op;

    assign shamt_ext = {{(`DATA_W-`SHAMT_W){1'b0}}, i_instr.r_fmt.shamt};
    assign imm_zext  = {{(`DATA_W-`IMM_W){1'b0}}, i_instr.i_fmt.imm};
    assign imm_sext  = {{(`DATA_W-`IMM_W){i_instr.i_fmt.imm[`IMM_W-1]}}, i_instr.i_fmt.imm};

    // Variable shifts map onto the fixed shift of the same kind.
    always_comb
    begin
        case (i_instr.r_fmt.func)
            `FUNC_AND:             func_op = decoder_pkg::ALU_AND;
            `FUNC_OR:              func_op = decoder_pkg::ALU_OR;
            `FUNC_XOR:             func_op = decoder_pkg::ALU_XOR;
            `FUNC_NOR:             func_op = decoder_pkg::ALU_NOR;
            `FUNC_SLL, `FUNC_SLLV: func_op = decoder_pkg::ALU_SLL;
            `FUNC_SRL, `FUNC_SRLV: func_op = decoder_pkg::ALU_SRL;
            `FUNC_SRA, `FUNC_SRAV: func_op = decoder_pkg::ALU_SRA;
            `FUNC_MOVN:            func_op = decoder_pkg::ALU_MOVN;
            `FUNC_MOVZ:            func_op = decoder_pkg::ALU_MOVZ;
            `FUNC_ADD:             func_op = decoder_pkg::ALU_ADD;
            `FUNC_ADDU:            func_op = decoder_pkg::ALU_ADDU;
            `FUNC_SUB:             func_op = decoder_pkg::ALU_SUB;
            `FUNC_SUBU:            func_op = decoder_pkg::ALU_SUBU;
            `FUNC_SLT:             func_op = decoder_pkg::ALU_SLT;
            `FUNC_SLTU:            func_op = decoder_pkg::ALU_SLTU;
            default:               func_op = decoder_pkg::ALU_NOP; // HI/LO, mul/div, flags.
        endcase

        case (i_instr.i_fmt.op)
            `OP_ANDI:  imm_op = decoder_pkg::ALU_AND;
            `OP_ORI:   imm_op = decoder_pkg::ALU_OR;
            `OP_XORI:  imm_op = decoder_pkg::ALU_XOR;
            `OP_LUI:   imm_op = decoder_pkg::ALU_LUI;
            `OP_ADDI:  imm_op = decoder_pkg::ALU_ADD;
            `OP_ADDIU: imm_op = decoder_pkg::ALU_ADDU;
            `OP_SLTI:  imm_op = decoder_pkg::ALU_SLT;
            `OP_SLTIU: imm_op = decoder_pkg::ALU_SLTU;
            default:   imm_op = decoder_pkg::ALU_NOP;
        endcase
    end

    always_comb
    begin
        o_alu.alu_op = decoder_pkg::ALU_NOP;
        o_alu.opr1   = '0;
        o_alu.opr2   = '0;

        case (i_instr.r_fmt.op)
            `OP_SPECIAL:
            begin
                o_alu.alu_op = func_op;
                case (i_instr.r_fmt.func)
                    `FUNC_SLL, `FUNC_SRL, `FUNC_SRA:
                    begin
                        o_alu.opr1 = i_rt_rdata; // Shift rt by shamt.
                        o_alu.opr2 = shamt_ext;
                    end
                    default:
                    begin
                        if (func_op != decoder_pkg::ALU_NOP)
                        begin
                            o_alu.opr1 = i_rs_rdata;
                            o_alu.opr2 = i_rt_rdata;
                        end
                    end
                endcase
            end

            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
            begin
                o_alu.alu_op = imm_op;
                o_alu.opr1   = i_rs_rdata;
                o_alu.opr2   = imm_zext; // Logical ops zero-extend.
            end

            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU:
            begin
                o_alu.alu_op = imm_op;
                o_alu.opr1   = i_rs_rdata;
                o_alu.opr2   = imm_sext; // Arithmetic and compares sign-extend.
            end

            default:
            begin
                o_alu.alu_op = decoder_pkg::ALU_NOP;
            end
        endcase
    end

endmodule

// ==== ctrl_decode.sv ====
`include "decoder_cfg.svh"

module ctrl_decode (
    input  decoder_pkg::instr_u       i_instr,
    output decoder_pkg::ctrl_bundle_t o_ctrl
);

    always_comb
    begin
        o_ctrl.gpr_waddr  = '0;
        o_ctrl.gpr_we     = 1'b0;
        o_ctrl.hi_we      = 1'b0;
        o_ctrl.lo_we      = 1'b0;
        o_ctrl.gpr_sel    = decoder_pkg::GPR_SEL_ALU;
        o_ctrl.lohi_sel   = decoder_pkg::LH_SEL_GPR;
        o_ctrl.is_jump    = 1'b0;
        o_ctrl.is_syscall = 1'b0;
        o_ctrl.is_eret    = 1'b0;
        o_ctrl.is_div     = 1'b0;
        o_ctrl.exc        = 1'b0;
        o_ctrl.exc_cause  = '0;

        case (i_instr.r_fmt.op)
            `OP_SPECIAL:
            begin
                case (i_instr.r_fmt.func)
                    `FUNC_AND, `FUNC_OR, `FUNC_XOR, `FUNC_NOR,
                    `FUNC_SLL, `FUNC_SLLV, `FUNC_SRA, `FUNC_SRAV,
                    `FUNC_SRL, `FUNC_SRLV, `FUNC_MOVN, `FUNC_MOVZ,
                    `FUNC_ADD, `FUNC_ADDU, `FUNC_SUB, `FUNC_SUBU,
                    `FUNC_SLT, `FUNC_SLTU:
                    begin
                        o_ctrl.gpr_waddr = i_instr.r_fmt.rd;
                        o_ctrl.gpr_we    = 1'b1;
                    end
                    `FUNC_MFHI:
                    begin
                        o_ctrl.gpr_waddr = i_instr.r_fmt.rd;
                        o_ctrl.gpr_we    = 1'b1;
                        o_ctrl.gpr_sel   = decoder_pkg::GPR_SEL_HI;
                    end
                    `FUNC_MFLO:
                    begin
                        o_ctrl.gpr_waddr = i_instr.r_fmt.rd;
                        o_ctrl.gpr_we    = 1'b1;
                        o_ctrl.gpr_sel   = decoder_pkg::GPR_SEL_LO;
                    end
                    `FUNC_MTHI: o_ctrl.hi_we = 1'b1;
                    `FUNC_MTLO: o_ctrl.lo_we = 1'b1;
                    `FUNC_MULT, `FUNC_MULTU:
                    begin
                        o_ctrl.hi_we    = 1'b1; // 64-bit product fills both.
                        o_ctrl.lo_we    = 1'b1;
                        o_ctrl.lohi_sel = decoder_pkg::LH_SEL_MUL;
                    end
                    `FUNC_DIV, `FUNC_DIVU:
                    begin
                        o_ctrl.hi_we    = 1'b1; // Remainder to HI, quotient to LO.
                        o_ctrl.lo_we    = 1'b1;
                        o_ctrl.lohi_sel = decoder_pkg::LH_SEL_DIV;
                        o_ctrl.is_div   = 1'b1;
                    end
                    `FUNC_JR: o_ctrl.is_jump = 1'b1;
                    `FUNC_SYSCALL:
                    begin
                        o_ctrl.is_syscall = 1'b1;
                        o_ctrl.exc        = 1'b1;
                        o_ctrl.exc_cause  = `EXC_SYS;
                    end
                    default:
                    begin
                        o_ctrl.exc       = 1'b1;
                        o_ctrl.exc_cause = `EXC_RI;
                    end
                endcase
            end

            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU:
            begin
                o_ctrl.gpr_waddr = i_instr.i_fmt.rt; // I-type writes rt.
                o_ctrl.gpr_we    = 1'b1;
            end

            `OP_COP0:
            begin
                if (i_instr.r_fmt.rs == `RS_ERET)
                begin
                    o_ctrl.is_eret = 1'b1;
                end
                else
                begin
                    o_ctrl.exc       = 1'b1;
                    o_ctrl.exc_cause = `EXC_RI;
                end
            end

            default:
            begin
                o_ctrl.exc       = 1'b1;
                o_ctrl.exc_cause = `EXC_RI;
            end
        endcase
    end

endmodule

// ==== id_ex_reg.sv ====
module id_ex_reg (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  decoder_pkg::alu_bundle_t  i_alu,
    input  decoder_pkg::ctrl_bundle_t i_ctrl,
    output logic                      o_valid,
    output decoder_pkg::decode_t      o_decode
);

    logic                      wr_ok;
    logic [7:0]                flags_d;
    logic [7:0]                flags_q;
    decoder_pkg::alu_bundle_t  alu_q;
    decoder_pkg::ctrl_bundle_t ctrl_q;

    assign wr_ok = ~i_ctrl.exc; // A faulting instruction never writes.

    assign flags_d = i_valid ? {i_ctrl.gpr_we & wr_ok, i_ctrl.hi_we & wr_ok,
                                i_ctrl.lo_we & wr_ok, i_ctrl.is_jump,
                                i_ctrl.is_syscall, i_ctrl.is_eret,
                                i_ctrl.is_div, i_ctrl.exc} : '0;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_valid <= 1'b0;
            flags_q <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            flags_q <= flags_d; // Idle cycles clear every enable.
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            alu_q  <= i_alu;
            ctrl_q <= i_ctrl;
        end
    end

    always_comb
    begin
        o_decode.alu  = alu_q;
        o_decode.ctrl = ctrl_q;
        {o_decode.ctrl.gpr_we, o_decode.ctrl.hi_we, o_decode.ctrl.lo_we,
         o_decode.ctrl.is_jump, o_decode.ctrl.is_syscall, o_decode.ctrl.is_eret,
         o_decode.ctrl.is_div, o_decode.ctrl.exc} = flags_q;
    end

endmodule

// ==== decoder_top.sv ====
`include "decoder_cfg.svh"

module decoder_top (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic                 i_valid,
    input  logic [`DATA_W-1:0]   i_instr,
    input  logic [`DATA_W-1:0]   i_rs_rdata,
    input  logic [`DATA_W-1:0]   i_rt_rdata,
    output logic                 o_valid,
    output decoder_pkg::decode_t o_decode
);

    decoder_pkg::instr_u       instr;
    decoder_pkg::alu_bundle_t  alu;
    decoder_pkg::ctrl_bundle_t ctrl;

    assign instr = decoder_pkg::instr_u'(i_instr);

    // Operand path and control path decode the same word in parallel.
    operand_select u_operand_select (
        .i_instr    (instr),
        .i_rs_rdata (i_rs_rdata),
        .i_rt_rdata (i_rt_rdata),
        .o_alu      (alu)
    );

    ctrl_decode u_ctrl_decode (
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    id_ex_reg u_id_ex_reg (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_alu    (alu),
        .i_ctrl   (ctrl),
        .o_valid  (o_valid),
        .o_decode (o_decode)
    );

endmodule

// ==== decoder_sva.sv ====
`include "decoder_cfg.svh"

module decoder_sva (
    input logic                 i_clk,
    input logic                 i_arst_n,
    input logic                 i_valid,
    input logic [`DATA_W-1:0]   i_instr,
    input logic [`DATA_W-1:0]   i_rs_rdata,
    input logic [`DATA_W-1:0]   i_rt_rdata,
    input logic                 o_valid,
    input decoder_pkg::decode_t o_decode
);

    decoder_pkg::instr_u       s_instr;
    logic [`DATA_W-1:0]        s_rs;
    logic [`DATA_W-1:0]        s_rt;
    logic [`FUNC_W-1:0]        fn;
    decoder_pkg::alu_op_e      r_op;
    decoder_pkg::ctrl_bundle_t c;
    decoder_pkg::alu_bundle_t  a;
    logic                      special;
    logic                      zx_imm;
    logic                      sx_imm;
    logic                      known;
    int                        n_errors = 0;

    function automatic void count_failure(input string what);
        $error("%s", what);
        n_errors++;
    endfunction

    // Instruction and register data now held in the decode register.
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            s_instr <= i_instr;
            s_rs    <= i_rs_rdata;
            s_rt    <= i_rt_rdata;
        end
    end

    always_comb
    begin
        case (fn)
            `FUNC_AND:             r_op = decoder_pkg::ALU_AND;
            `FUNC_OR:              r_op = decoder_pkg::ALU_OR;
            `FUNC_XOR:             r_op = decoder_pkg::ALU_XOR;
            `FUNC_NOR:             r_op = decoder_pkg::ALU_NOR;
            `FUNC_SLL, `FUNC_SLLV: r_op = decoder_pkg::ALU_SLL;
            `FUNC_SRL, `FUNC_SRLV: r_op = decoder_pkg::ALU_SRL;
            `FUNC_SRA, `FUNC_SRAV: r_op = decoder_pkg::ALU_SRA;
            `FUNC_MOVN:            r_op = decoder_pkg::ALU_MOVN;
            `FUNC_MOVZ:            r_op = decoder_pkg::ALU_MOVZ;
            `FUNC_ADD:             r_op = decoder_pkg::ALU_ADD;
            `FUNC_ADDU:            r_op = decoder_pkg::ALU_ADDU;
            `FUNC_SUB:             r_op = decoder_pkg::ALU_SUB;
            `FUNC_SUBU:            r_op = decoder_pkg::ALU_SUBU;
            `FUNC_SLT:             r_op = decoder_pkg::ALU_SLT;
            `FUNC_SLTU:            r_op = decoder_pkg::ALU_SLTU;
            default:               r_op = decoder_pkg::ALU_NOP; // Not a register ALU op.
        endcase
    end

    assign fn      = s_instr.r_fmt.func;
    assign special = s_instr.r_fmt.op == `OP_SPECIAL;
    assign c       = o_decode.ctrl;
    assign a       = o_decode.alu;
    assign zx_imm  = s_instr.i_fmt.op inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
    assign sx_imm  = s_instr.i_fmt.op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
    assign known   = (special && (r_op != decoder_pkg::ALU_NOP || fn inside {`FUNC_MFHI,
                     `FUNC_MFLO, `FUNC_MTHI, `FUNC_MTLO, `FUNC_MULT, `FUNC_MULTU, `FUNC_DIV,
                     `FUNC_DIVU, `FUNC_JR, `FUNC_SYSCALL})) || zx_imm || sx_imm
                     || (s_instr.r_fmt.op == `OP_COP0 && s_instr.r_fmt.rs == `RS_ERET);

    a_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid == $past(i_valid)) else count_failure("o_valid not one cycle after i_valid");

    a_idle: assert property (@(posedge i_clk) !o_valid |-> !(c.gpr_we || c.hi_we || c.lo_we
        || c.is_jump || c.is_syscall || c.is_eret || c.is_div || c.exc))
        else count_failure("enable or flag set on an idle cycle");

    a_exc_no_write: assert property (@(posedge i_clk) c.exc |-> !(c.gpr_we || c.hi_we || c.lo_we))
        else count_failure("write enable set together with an exception");

    a_r_alu: assert property (@(posedge i_clk) o_valid && special && r_op != decoder_pkg::ALU_NOP
        |-> a.alu_op == r_op && c.gpr_we && c.gpr_waddr == s_instr.r_fmt.rd
        && c.gpr_sel == decoder_pkg::GPR_SEL_ALU
        && (fn inside {`FUNC_SLL, `FUNC_SRL, `FUNC_SRA}
            ? (a.opr1 == s_rt && a.opr2 == `DATA_W'(s_instr.r_fmt.shamt))
            : (a.opr1 == s_rs && a.opr2 == s_rt)))
        else count_failure("register ALU op decoded wrongly");

    a_imm: assert property (@(posedge i_clk) o_valid && (zx_imm || sx_imm)
        |-> a.opr1 == s_rs && c.gpr_we && c.gpr_waddr == s_instr.i_fmt.rt
        && a.opr2 == (zx_imm ? `DATA_W'(s_instr.i_fmt.imm)
                             : `DATA_W'(signed'(s_instr.i_fmt.imm))))
        else count_failure("immediate op decoded wrongly");

    a_mfhilo: assert property (@(posedge i_clk) o_valid && special
        && fn inside {`FUNC_MFHI, `FUNC_MFLO} |-> c.gpr_we && c.gpr_waddr == s_instr.r_fmt.rd
        && c.gpr_sel == (fn == `FUNC_MFHI ? decoder_pkg::GPR_SEL_HI : decoder_pkg::GPR_SEL_LO))
        else count_failure("MFHI or MFLO decoded wrongly");

    a_mthilo: assert property (@(posedge i_clk) o_valid && special
        && fn inside {`FUNC_MTHI, `FUNC_MTLO} |-> c.hi_we == (fn == `FUNC_MTHI)
        && c.lo_we == (fn == `FUNC_MTLO) && !c.gpr_we && c.lohi_sel == decoder_pkg::LH_SEL_GPR)
        else count_failure("MTHI or MTLO decoded wrongly");

    a_muldiv: assert property (@(posedge i_clk) o_valid && special
        && fn inside {`FUNC_MULT, `FUNC_MULTU, `FUNC_DIV, `FUNC_DIVU}
        |-> c.hi_we && c.lo_we && c.is_div == (fn inside {`FUNC_DIV, `FUNC_DIVU})
        && c.lohi_sel == (fn inside {`FUNC_DIV, `FUNC_DIVU} ? decoder_pkg::LH_SEL_DIV
                                                             : decoder_pkg::LH_SEL_MUL))
        else count_failure("multiply or divide decoded wrongly");

    a_syscall: assert property (@(posedge i_clk) o_valid && special && fn == `FUNC_SYSCALL
        |-> c.is_syscall && c.exc && c.exc_cause == `EXC_SYS)
        else count_failure("SYSCALL decoded wrongly");

    a_jr: assert property (@(posedge i_clk) o_valid && special && fn == `FUNC_JR
        |-> c.is_jump && !c.exc) else count_failure("JR decoded wrongly");

    a_eret: assert property (@(posedge i_clk) o_valid && s_instr.r_fmt.op == `OP_COP0
        && s_instr.r_fmt.rs == `RS_ERET |-> c.is_eret && !c.exc)
        else count_failure("ERET decoded wrongly");

    a_reserved: assert property (@(posedge i_clk) o_valid && !known
        |-> c.exc && c.exc_cause == `EXC_RI) else count_failure("reserved encoding not trapped");

endmodule

bind decoder_top decoder_sva u_sva (.*);

// ==== tb_decoder.sv ====
`include "decoder_cfg.svh"

module tb_decoder;

    localparam int N_TESTS    = 6;
    localparam int N_STROBES  = 40;
    localparam int MAX_CYCLES = 2000; // Covers six tests of about 60 cycles and reset many times.

    logic                 clk;
    logic                 arst_n;
    logic                 valid;
    logic [`DATA_W-1:0]   instr;
    logic [`DATA_W-1:0]   rs_rdata;
    logic [`DATA_W-1:0]   rt_rdata;
    logic                 o_valid;
    decoder_pkg::decode_t o_decode;

    integer seed;
    int     cycles;
    int     pulses = 0;
    int     n_pass;
    int     n_fail;

    logic [5:0] r_funcs [18] = '{`FUNC_AND, `FUNC_OR, `FUNC_XOR, `FUNC_NOR, `FUNC_SLL,
        `FUNC_SLLV, `FUNC_SRA, `FUNC_SRAV, `FUNC_SRL, `FUNC_SRLV, `FUNC_MOVN, `FUNC_MOVZ,
        `FUNC_ADD, `FUNC_ADDU, `FUNC_SUB, `FUNC_SUBU, `FUNC_SLT, `FUNC_SLTU};
    logic [5:0] hl_funcs [8] = '{`FUNC_MFHI, `FUNC_MFLO, `FUNC_MTHI, `FUNC_MTLO,
        `FUNC_MULT, `FUNC_MULTU, `FUNC_DIV, `FUNC_DIVU};
    logic [5:0] i_ops [8] = '{`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
        `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
    // Branches, loads, stores, traps, SPECIAL2 and other encodings the decoder rejects.
    logic [5:0] bad_funcs [8] = '{6'h01, 6'h05, 6'h09, 6'h0d, 6'h0f, 6'h14, 6'h30, 6'h3f};
    logic [5:0] bad_ops [8]   = '{6'h02, 6'h03, 6'h04, 6'h23, 6'h2b, 6'h1c, 6'h33, 6'h3f};
    string      names [N_TESTS] = '{"r_type_alu", "immediate", "hilo_muldiv", "flags",
        "reserved", "mixed"};

    decoder_top UUT (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_valid    (valid),
        .i_instr    (instr),
        .i_rs_rdata (rs_rdata),
        .i_rt_rdata (rt_rdata),
        .o_valid    (o_valid),
        .o_decode   (o_decode)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (o_valid)
            pulses <= pulses + 1;
    end

    initial
    begin
        for (cycles = 0; cycles < MAX_CYCLES; cycles++)
            @(posedge clk);
        $display("run timed out after %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    task automatic pick(input int kind, output logic [`DATA_W-1:0] w);
        logic [`DATA_W-1:0] r;
        int                 idx;
        r   = $random(seed);
        idx = $unsigned($random(seed)) % 24;
        case (kind)
            0: w = {`OP_SPECIAL, r[25:6], r_funcs[idx % 18]};
            1: w = {i_ops[idx % 8], r[25:0]};
            2: w = {`OP_SPECIAL, r[25:6], hl_funcs[idx % 8]};
            3: w = (idx % 3 == 0) ? {`OP_SPECIAL, r[25:6], `FUNC_JR}
                 : (idx % 3 == 1) ? {`OP_SPECIAL, r[25:6], `FUNC_SYSCALL}
                 : {`OP_COP0, `RS_ERET, r[20:0]};
            default: w = (idx % 3 == 0) ? {`OP_SPECIAL, r[25:6], bad_funcs[idx % 8]}
                       : (idx % 3 == 1) ? {bad_ops[idx % 8], r[25:0]}
                       : {`OP_COP0, 1'b0, r[24:0]}; // COP0 moves are not decoded.
        endcase
    endtask

    task automatic run_test(input int t);
        int                 start_pulses;
        int                 start_errs;
        int                 got;
        int                 errs;
        logic [`DATA_W-1:0] w;
        start_pulses = pulses;
        start_errs   = UUT.u_sva.n_errors;
        for (int k = 0; k < N_STROBES; k++)
        begin
            pick((t == N_TESTS - 1) ? $unsigned($random(seed)) % 5 : t, w);
            @(posedge clk);
            valid    <= 1'b1;
            instr    <= w;
            rs_rdata <= $random(seed);
            rt_rdata <= $random(seed);
            if (($random(seed) & 3) == 0)
            begin
                @(posedge clk);
                valid <= 1'b0;
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        @(posedge clk); // Last decode leaves the register one cycle after its strobe.
        @(negedge clk);
        got  = pulses - start_pulses;
        errs = UUT.u_sva.n_errors - start_errs;
        if (got != N_STROBES)
        begin
            $display("mismatch %s: expected %0d, actual %0d", names[t], N_STROBES, got);
            n_fail++;
        end
        else if (errs != 0)
        begin
            $display("%s failed with %0d decode assertion errors", names[t], errs);
            n_fail++;
        end
        else
        begin
            $display("%s passed", names[t]);
            n_pass++;
        end
    endtask

    initial
    begin
        seed     = 32'hcf3b;
        arst_n   = 1'b0;
        valid    = 1'b0;
        instr    = '0;
        rs_rdata = '0;
        rt_rdata = '0;
        n_pass   = 0;
        n_fail   = 0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (int t = 0; t < N_TESTS; t++)
            run_test(t);
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
decoder_pkg.sv
operand_select.sv
ctrl_decode.sv
id_ex_reg.sv
decoder_top.sv
decoder_sva.sv
tb_decoder.sv
